//--- flist.f
+incdir+.
conv_mem_pkg.sv
conv_calc_pkg.sv
conv_seq.sv
conv_addr_gen.sv
conv_mac.sv
conv_writeback.sv
conv_layer.sv
tb_clock.sv
tb_mem_model.sv
tb_conv_layer.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_conv_layer
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
BUILD_FLAGS := --binary --timing -Wno-fatal -j 0
LINT_FLAGS  := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module tb_conv_layer;

    localparam int PERIOD_NS       = 40;
    localparam int NUM_TESTS       = 6;
    localparam int PIXEL_CYCLES    = 78;
    localparam int TAPS            = `KERNEL_SIZE * `KERNEL_SIZE;
    localparam int IMG_WORDS       = `IMAGE_SIZE * `IMAGE_SIZE;
    localparam int OUT_WORDS       = `OUTPUT_SIZE * `OUTPUT_SIZE;
    localparam int RUN_CYCLES      = `NUM_FILTERS * OUT_WORDS * PIXEL_CYCLES;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * RUN_CYCLES * 2;
    localparam int SAT_MAX         = (1 << (`DATA_W - 1)) - 1;
    localparam int SAT_MIN         = -(1 << (`DATA_W - 1));

    logic                       clk;
    logic                       rst;
    logic                       en;
    logic                       clear;
    logic [`IMG_SEL_W-1:0]      image;
    conv_calc_pkg::data_t       wt_data;
    conv_calc_pkg::data_t       in_data;
    conv_mem_pkg::wt_rd_t       wt_rd;
    conv_mem_pkg::in_rd_t       in_rd;
    conv_mem_pkg::res_wr_t      res_wr;
    logic                       done;

    logic [15:0]                lfsr;
    int                         errors;
    int                         checks;

    tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(16)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    conv_layer dut (
        .clk     (clk),
        .rst     (rst),
        .en      (en),
        .image   (image),
        .wt_data (wt_data),
        .in_data (in_data),
        .wt_rd   (wt_rd),
        .in_rd   (in_rd),
        .res_wr  (res_wr),
        .done    (done)
    );

    tb_mem_model mem (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .wt_rd   (wt_rd),
        .in_rd   (in_rd),
        .res_wr  (res_wr),
        .wt_data (wt_data),
        .in_data (in_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int expected_pixel(input int f, input int r, input int c, input int img);
        int acc;
        int px;
        acc = int'(mem.wt_mem[`BIAS_BASE + f]) * (1 << `FRAC_BITS);
        for (int kr = 0; kr < `KERNEL_SIZE; kr++)
        begin
            for (int kc = 0; kc < `KERNEL_SIZE; kc++)
            begin
                px  = img * IMG_WORDS + (r + kr) * `IMAGE_SIZE + c + kc;
                acc = acc + int'(mem.wt_mem[f * TAPS + kr * `KERNEL_SIZE + kc]) *
                            int'(mem.in_mem[px]);
            end
        end
        acc = acc >>> `FRAC_BITS;
        if (acc > SAT_MAX)
            acc = SAT_MAX;
        else if (acc < SAT_MIN)
            acc = SAT_MIN;
        return acc;
    endfunction

    task automatic check_equal(input int actual, input int expected, input string what);
        checks++;
        if (actual != expected)
        begin
            errors++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic load_random_weights();
        for (int a = 0; a < `BIAS_BASE + `NUM_FILTERS; a++)
            mem.wt_mem[a] = conv_calc_pkg::data_t'(rand_bits(`DATA_W));
    endtask

    task automatic load_random_image(input int img);
        for (int i = 0; i < IMG_WORDS; i++)
            mem.in_mem[img * IMG_WORDS + i] = conv_calc_pkg::data_t'(rand_bits(`DATA_W));
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < RUN_CYCLES + 100)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
        begin
            errors++;
            $display("Run did not finish: no done pulse after %0d cycles", cycles);
        end
        else
        begin
            @(negedge clk);
            check_equal(int'(done), 0, "done lasts one cycle");
        end
    endtask

    task automatic run_layer(input int img);
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        image <= `IMG_SEL_W'(img);
        en    <= 1'b1;
        wait_done();
    endtask

    task automatic stop_layer();
        @(posedge clk);
        en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic compare_results(input int img, input string tag);
        int addr;
        for (int f = 0; f < `NUM_FILTERS; f++)
            for (int r = 0; r < `OUTPUT_SIZE; r++)
                for (int c = 0; c < `OUTPUT_SIZE; c++)
                begin
                    addr = f * OUT_WORDS + r * `OUTPUT_SIZE + c;
                    check_equal(mem.res_count[addr], 1,
                                $sformatf("%s writes f%0d r%0d c%0d", tag, f, r, c));
                    check_equal(int'(mem.res_mem[addr]), expected_pixel(f, r, c, img),
                                $sformatf("%s result f%0d r%0d c%0d", tag, f, r, c));
                end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_idle_quiet();
        repeat (20)
        begin
            @(negedge clk);
            check_equal(int'(wt_rd.en), 0, "wt_rd.en while idle");
            check_equal(int'(in_rd.en), 0, "in_rd.en while idle");
            check_equal(int'(res_wr.en), 0, "res_wr.en while idle");
            check_equal(int'(res_wr.we), 0, "res_wr.we while idle");
            check_equal(int'(done), 0, "done while idle");
        end
    endtask

    task automatic test_zero_weights();
        conv_calc_pkg::data_t bias [`NUM_FILTERS];
        for (int a = 0; a < `BIAS_BASE; a++)
            mem.wt_mem[a] = '0;
        for (int f = 0; f < `NUM_FILTERS; f++)
        begin
            bias[f] = conv_calc_pkg::data_t'(rand_bits(4) - 8);
            mem.wt_mem[`BIAS_BASE + f] = bias[f];
        end
        load_random_image(0);
        run_layer(0);
        compare_results(0, "zero weights");
        for (int f = 0; f < `NUM_FILTERS; f++)
            for (int i = 0; i < OUT_WORDS; i++)
                check_equal(int'(mem.res_mem[f * OUT_WORDS + i]), int'(bias[f]),
                            "zero weights bias only");
        stop_layer();
    endtask

    task automatic test_random_image0();
        load_random_weights();
        load_random_image(0);
        run_layer(0);
        compare_results(0, "random image 0");
        stop_layer();
    endtask

    task automatic test_saturation();
        // Filter 0 drives far positive, filter 1 far negative
        for (int t = 0; t < TAPS; t++)
        begin
            mem.wt_mem[t]        = conv_calc_pkg::data_t'(SAT_MAX);
            mem.wt_mem[TAPS + t] = conv_calc_pkg::data_t'(SAT_MIN);
        end
        mem.wt_mem[`BIAS_BASE]     = conv_calc_pkg::data_t'(100);
        mem.wt_mem[`BIAS_BASE + 1] = conv_calc_pkg::data_t'(-100);
        for (int i = 0; i < IMG_WORDS; i++)
            mem.in_mem[i] = conv_calc_pkg::data_t'(SAT_MAX);
        run_layer(0);
        compare_results(0, "saturation");
        for (int i = 0; i < OUT_WORDS; i++)
        begin
            check_equal(int'(mem.res_mem[i]), SAT_MAX, "clamp to maximum");
            check_equal(int'(mem.res_mem[OUT_WORDS + i]), SAT_MIN, "clamp to minimum");
        end
        stop_layer();
    endtask

    task automatic test_image_select();
        load_random_weights();
        for (int img = 0; img < `NUM_IMAGES; img++)
            load_random_image(img);
        run_layer(2);
        compare_results(2, "image 2");
        check_equal(int'(mem.in_lo >= 2 * IMG_WORDS), 1, "lowest input read inside image 2");
        check_equal(int'(mem.in_hi < 3 * IMG_WORDS), 1, "highest input read inside image 2");
        stop_layer();
    endtask

    task automatic test_rearm();
        load_random_weights();
        load_random_image(1);
        run_layer(1);
        // en still high, the engine must stay put
        repeat (2 * PIXEL_CYCLES)
        begin
            @(negedge clk);
            check_equal(int'(wt_rd.en), 0, "no read while en held after done");
            check_equal(int'(done), 0, "no second done while en held");
        end
        compare_results(1, "first run");
        stop_layer();
        load_random_weights();
        run_layer(1);
        compare_results(1, "second run");
        stop_layer();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        en     <= 1'b0;
        image  <= '0;
        clear  <= 1'b0;
        lfsr   = 16'd21;
        errors = 0;
        checks = 0;
        @(negedge clk);
        while (rst)
            @(negedge clk);
        test_idle_quiet();
        test_zero_weights();
        test_random_image0();
        test_saturation();
        test_image_select();
        test_rearm();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: simulation still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module tb_mem_model
(
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       clear,
    input  wire conv_mem_pkg::wt_rd_t       wt_rd,
    input  wire conv_mem_pkg::in_rd_t       in_rd,
    input  wire conv_mem_pkg::res_wr_t      res_wr,
    output conv_calc_pkg::data_t            wt_data,
    output conv_calc_pkg::data_t            in_data
);

    localparam int LAT = `READ_LATENCY;

    conv_calc_pkg::data_t   wt_mem    [0:(1 << `WADDR_W) - 1];
    conv_calc_pkg::data_t   in_mem    [0:(1 << `IADDR_W) - 1];
    conv_calc_pkg::data_t   res_mem   [0:(1 << `RADDR_W) - 1];
    int                     res_count [0:(1 << `RADDR_W) - 1];
    int                     in_lo;
    int                     in_hi;

    logic [LAT-1:0]         wt_vld;
    logic [LAT-1:0]         in_vld;
    logic [`WADDR_W-1:0]    wt_pipe [0:LAT-1];
    logic [`IADDR_W-1:0]    in_pipe [0:LAT-1];

    ////////////////////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////////////////////

    // Last stage holds the request during its data cycle
    always @(posedge clk)
    begin
        if (rst)
        begin
            wt_vld <= '0;
            in_vld <= '0;
        end
        else
        begin
            wt_vld <= {wt_vld[LAT-2:0], wt_rd.en};
            in_vld <= {in_vld[LAT-2:0], in_rd.en};
        end
        wt_pipe[0] <= wt_rd.addr;
        in_pipe[0] <= in_rd.addr;
        for (int i = 1; i < LAT; i++)
        begin
            wt_pipe[i] <= wt_pipe[i-1];
            in_pipe[i] <= in_pipe[i-1];
        end
    end

    assign wt_data = wt_vld[LAT-1] ? wt_mem[wt_pipe[LAT-1]] : '0;
    assign in_data = in_vld[LAT-1] ? in_mem[in_pipe[LAT-1]] : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Result capture
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (clear)
        begin
            for (int i = 0; i < (1 << `RADDR_W); i++)
                res_count[i] <= 0;
            in_lo <= 1 << `IADDR_W;
            in_hi <= -1;
        end
        else
        begin
            if (res_wr.en && res_wr.we)
            begin
                res_mem[res_wr.addr]   <= res_wr.data;
                res_count[res_wr.addr] <= res_count[res_wr.addr] + 1;
            end
            // Span of input addresses seen since the last clear
            if (in_rd.en)
            begin
                if (int'(in_rd.addr) < in_lo)
                    in_lo <= int'(in_rd.addr);
                if (int'(in_rd.addr) > in_hi)
                    in_hi <= int'(in_rd.addr);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held over the first cycles
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_layer
(
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       en,
    input  wire logic [`IMG_SEL_W-1:0]      image,
    input  wire conv_calc_pkg::data_t       wt_data,
    input  wire conv_calc_pkg::data_t       in_data,
    output conv_mem_pkg::wt_rd_t            wt_rd,
    output conv_mem_pkg::in_rd_t            in_rd,
    output conv_mem_pkg::res_wr_t           res_wr,
    output logic                            done
);

    conv_calc_pkg::phase_t      phase;
    conv_calc_pkg::mac_ctl_t    mac_ctl;
    conv_calc_pkg::acc_t        acc;
    logic [`FILTER_W-1:0]       filter;
    logic [`POS_W-1:0]          out_row;
    logic [`POS_W-1:0]          out_col;
    logic [`TAP_W-1:0]          tap;
    logic                       wt_rd_en;
    logic                       in_rd_en;
    logic                       store;
    logic [`WADDR_W-1:0]        wt_addr;
    logic [`IADDR_W-1:0]        in_addr;
    logic [`RADDR_W-1:0]        res_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Control and addressing
    ////////////////////////////////////////////////////////////////////////////

    conv_seq u_seq (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .phase    (phase),
        .filter   (filter),
        .out_row  (out_row),
        .out_col  (out_col),
        .tap      (tap),
        .wt_rd_en (wt_rd_en),
        .in_rd_en (in_rd_en),
        .mac_ctl  (mac_ctl),
        .store    (store),
        .done     (done)
    );

    conv_addr_gen u_addr_gen (
        .image    (image),
        .phase    (phase),
        .filter   (filter),
        .out_row  (out_row),
        .out_col  (out_col),
        .tap      (tap),
        .wt_addr  (wt_addr),
        .in_addr  (in_addr),
        .res_addr (res_addr)
    );

    assign wt_rd.en   = wt_rd_en;
    assign wt_rd.addr = wt_addr;
    assign in_rd.en   = in_rd_en;
    assign in_rd.addr = in_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    conv_mac u_mac (
        .clk      (clk),
        .rst      (rst),
        .mac_ctl  (mac_ctl),
        .wt_data  (wt_data),
        .in_data  (in_data),
        .acc      (acc)
    );

    conv_writeback u_writeback (
        .clk      (clk),
        .rst      (rst),
        .store    (store),
        .acc      (acc),
        .res_addr (res_addr),
        .res_wr   (res_wr)
    );

endmodule

`default_nettype wire

//--- conv_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_writeback
(
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       store,
    input  wire conv_calc_pkg::acc_t        acc,
    input  wire logic [`RADDR_W-1:0]        res_addr,
    output conv_mem_pkg::res_wr_t           res_wr
);

    localparam int SAT_MAX = (1 << (`DATA_W - 1)) - 1;
    localparam int SAT_MIN = -(1 << (`DATA_W - 1));

    conv_calc_pkg::acc_t  scaled;
    conv_calc_pkg::data_t sat;

    assign scaled = acc >>> `FRAC_BITS;

    // Clamp to the signed result range
    always_comb
    begin
        if (scaled > conv_calc_pkg::acc_t'(SAT_MAX))
            sat = conv_calc_pkg::data_t'(SAT_MAX);
        else if (scaled < conv_calc_pkg::acc_t'(SAT_MIN))
            sat = conv_calc_pkg::data_t'(SAT_MIN);
        else
            sat = conv_calc_pkg::data_t'(scaled);
    end

    always_ff @(posedge clk)
    begin
        if (store)
        begin
            res_wr.addr <= res_addr;
            res_wr.data <= sat;
        end
        if (rst)
        begin
            res_wr.en <= 1'b0;
            res_wr.we <= 1'b0;
        end
        else
        begin
            res_wr.en <= store;
            res_wr.we <= store;
        end
    end

endmodule

`default_nettype wire

//--- conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_mac
(
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire conv_calc_pkg::mac_ctl_t    mac_ctl,
    input  wire conv_calc_pkg::data_t       wt_data,
    input  wire conv_calc_pkg::data_t       in_data,
    output conv_calc_pkg::acc_t             acc
);

    conv_calc_pkg::data_t                weight;
    logic signed [2*`DATA_W-1:0]         product;
    conv_calc_pkg::acc_t                 bias_seed;

    assign product = weight * in_data;

    // Bias aligned to the product's fraction bits
    assign bias_seed = conv_calc_pkg::acc_t'(wt_data) <<< `FRAC_BITS;

    // Weight held until its pixel arrives
    always_ff @(posedge clk)
    begin
        if (mac_ctl.load_weight)
            weight <= wt_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            acc <= '0;
        else if (mac_ctl.load_bias)
            acc <= bias_seed;
        else if (mac_ctl.accumulate)
            acc <= acc + conv_calc_pkg::acc_t'(product);
    end

endmodule

`default_nettype wire

//--- conv_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_addr_gen
(
    input  wire logic [`IMG_SEL_W-1:0]      image,
    input  wire conv_calc_pkg::phase_t      phase,
    input  wire logic [`FILTER_W-1:0]       filter,
    input  wire logic [`POS_W-1:0]          out_row,
    input  wire logic [`POS_W-1:0]          out_col,
    input  wire logic [`TAP_W-1:0]          tap,
    output logic [`WADDR_W-1:0]             wt_addr,
    output logic [`IADDR_W-1:0]             in_addr,
    output logic [`RADDR_W-1:0]             res_addr
);

    localparam int TAPS = `KERNEL_SIZE * `KERNEL_SIZE;

    logic [`KPOS_W-1:0] k_row;
    logic [`KPOS_W-1:0] k_col;

    // Walk the kernel row/column pair in step with the tap index
    always_comb
    begin
        int row_i;
        int col_i;
        row_i = 0;
        col_i = 0;
        k_row = '0;
        k_col = '0;
        for (int i = 0; i < TAPS; i++)
        begin
            if (i == int'(tap))
            begin
                k_row = `KPOS_W'(row_i);
                k_col = `KPOS_W'(col_i);
            end
            if (col_i == `KERNEL_SIZE - 1)
            begin
                col_i = 0;
                row_i = row_i + 1;
            end
            else
                col_i = col_i + 1;
        end
    end

    assign wt_addr = (phase == conv_calc_pkg::load_bias) ?
                     `WADDR_W'(`BIAS_BASE + filter) :
                     `WADDR_W'(filter * TAPS + tap);

    assign in_addr = `IADDR_W'(image * (`IMAGE_SIZE * `IMAGE_SIZE) +
                               (out_row + k_row) * `IMAGE_SIZE + out_col + k_col);

    assign res_addr = `RADDR_W'(filter * (`OUTPUT_SIZE * `OUTPUT_SIZE) +
                                out_row * `OUTPUT_SIZE + out_col);

endmodule

`default_nettype wire

//--- conv_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_seq
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    en,
    output conv_calc_pkg::phase_t        phase,
    output logic [`FILTER_W-1:0]         filter,
    output logic [`POS_W-1:0]            out_row,
    output logic [`POS_W-1:0]            out_col,
    output logic [`TAP_W-1:0]            tap,
    output logic                         wt_rd_en,
    output logic                         in_rd_en,
    output conv_calc_pkg::mac_ctl_t      mac_ctl,
    output logic                         store,
    output logic                         done
);

    localparam logic [`FILTER_W-1:0] END_FILTER = `FILTER_W'(`NUM_FILTERS);
    localparam logic [`POS_W-1:0]    LAST_POS   = `POS_W'(`OUTPUT_SIZE - 1);
    localparam logic [`TAP_W-1:0]    LAST_TAP   = `TAP_W'(`KERNEL_SIZE * `KERNEL_SIZE - 1);
    localparam logic [`WAIT_W-1:0]   LAST_WAIT  = `WAIT_W'(`READ_LATENCY);

    logic [`WAIT_W-1:0] wait_cnt;
    logic               armed;
    logic               issue;
    logic               land;

    // Request goes out on the first wait cycle, data lands on the last
    assign issue = en && (wait_cnt == '0);
    assign land  = en && (wait_cnt == LAST_WAIT);

    assign wt_rd_en = issue && (phase == conv_calc_pkg::load_bias ||
                                phase == conv_calc_pkg::fetch_weight);
    assign in_rd_en = issue && (phase == conv_calc_pkg::fetch_input);

    assign mac_ctl.load_bias   = land && (phase == conv_calc_pkg::load_bias);
    assign mac_ctl.load_weight = land && (phase == conv_calc_pkg::fetch_weight);
    assign mac_ctl.accumulate  = land && (phase == conv_calc_pkg::fetch_input);

    assign store = en && (phase == conv_calc_pkg::store);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase    <= conv_calc_pkg::idle;
            armed    <= 1'b1;
            done     <= 1'b0;
            wait_cnt <= '0;
            filter   <= '0;
            out_row  <= '0;
            out_col  <= '0;
            tap      <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (!en)
            begin
                // A new run needs en seen low first
                if (phase == conv_calc_pkg::idle)
                    armed <= 1'b1;
            end
            else
            begin
                case (phase)
                    conv_calc_pkg::idle:
                    begin
                        if (armed)
                        begin
                            armed    <= 1'b0;
                            wait_cnt <= '0;
                            filter   <= '0;
                            out_row  <= '0;
                            out_col  <= '0;
                            tap      <= '0;
                            phase    <= conv_calc_pkg::check;
                        end
                    end
                    conv_calc_pkg::check:
                    begin
                        if (filter == END_FILTER)
                        begin
                            done  <= 1'b1;
                            phase <= conv_calc_pkg::idle;
                        end
                        else
                            phase <= conv_calc_pkg::load_bias;
                    end
                    conv_calc_pkg::load_bias:
                    begin
                        if (land)
                        begin
                            wait_cnt <= '0;
                            phase    <= conv_calc_pkg::fetch_weight;
                        end
                        else
                            wait_cnt <= wait_cnt + 1'b1;
                    end
                    conv_calc_pkg::fetch_weight:
                    begin
                        if (land)
                        begin
                            wait_cnt <= '0;
                            phase    <= conv_calc_pkg::fetch_input;
                        end
                        else
                            wait_cnt <= wait_cnt + 1'b1;
                    end
                    conv_calc_pkg::fetch_input:
                    begin
                        if (land)
                        begin
                            wait_cnt <= '0;
                            if (tap == LAST_TAP)
                            begin
                                tap   <= '0;
                                phase <= conv_calc_pkg::store;
                            end
                            else
                            begin
                                tap   <= tap + 1'b1;
                                phase <= conv_calc_pkg::fetch_weight;
                            end
                        end
                        else
                            wait_cnt <= wait_cnt + 1'b1;
                    end
                    conv_calc_pkg::store:
                    begin
                        // Column first, then row, then filter
                        phase <= conv_calc_pkg::check;
                        if (out_col == LAST_POS)
                        begin
                            out_col <= '0;
                            if (out_row == LAST_POS)
                            begin
                                out_row <= '0;
                                filter  <= filter + 1'b1;
                            end
                            else
                                out_row <= out_row + 1'b1;
                        end
                        else
                            out_col <= out_col + 1'b1;
                    end
                    default:
                        phase <= conv_calc_pkg::idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- conv_calc_pkg.sv
`default_nettype none

`include "conv_cfg.svh"

package conv_calc_pkg;

    // Pixel, weight, bias and result samples
    typedef logic signed [`DATA_W-1:0] data_t;

    // Accumulator, bias and products carry FRAC_BITS extra fraction bits
    typedef logic signed [`ACC_W-1:0] acc_t;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        idle,
        check,
        load_bias,
        fetch_weight,
        fetch_input,
        store
    } phase_t;

    // What the MAC captures this cycle
    typedef struct packed {
        logic load_bias;
        logic load_weight;
        logic accumulate;
    } mac_ctl_t;

endpackage

`default_nettype wire

//--- conv_mem_pkg.sv
`default_nettype none

`include "conv_cfg.svh"

package conv_mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Read requests, one enable cycle per request
    ////////////////////////////////////////////////////////////////////////////

    // Weight or bias read
    typedef struct packed {
        logic                en;
        logic [`WADDR_W-1:0] addr;
    } wt_rd_t;

    // Input pixel read
    typedef struct packed {
        logic                en;
        logic [`IADDR_W-1:0] addr;
    } in_rd_t;

    ////////////////////////////////////////////////////////////////////////////
    // Result write
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                en;
        logic                we;
        logic [`RADDR_W-1:0] addr;
        logic [`DATA_W-1:0]  data;
    } res_wr_t;

endpackage

`default_nettype wire

//--- conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Layer geometry
////////////////////////////////////////////////////////////////////////////

`define IMAGE_SIZE   8
`define KERNEL_SIZE  3
`define OUTPUT_SIZE  (`IMAGE_SIZE - `KERNEL_SIZE + 1)
`define NUM_FILTERS  2
`define NUM_IMAGES   4

// Arithmetic
`define DATA_W       8
`define ACC_W        20
`define FRAC_BITS    4

// Memory ports
`define READ_LATENCY 3
`define WADDR_W      5
`define IADDR_W      8
`define RADDR_W      7
`define IMG_SEL_W    2

// Biases sit right after the last filter's weights
`define BIAS_BASE    (`NUM_FILTERS * `KERNEL_SIZE * `KERNEL_SIZE)

// Counter widths
`define FILTER_W     2
`define POS_W        3
`define TAP_W        4
`define KPOS_W       2
`define WAIT_W       2

`endif
